// ==== design/decodePkg.sv ====
package decodePkg;

	// ==================================================
	// opcodes
	// ==================================================
	// the low nibble picks the operation and the upper bits pick the form
	// codes not listed here are undefined and decode as no class
	typedef enum logic [6:0]
	{
		// register-register forms, constant in the 8-bit slot
		OP_ADD_3R  = 7'h01, OP_SUB_3R  = 7'h02, OP_MUL_3R  = 7'h03,
		OP_AND_3R  = 7'h04, OP_OR_3R   = 7'h05, OP_EOR_3R  = 7'h06,
		OP_BIT_3R  = 7'h07, OP_CMP_3R  = 7'h08, OP_CMPU_3R = 7'h09,
		// shifts only come in the 3R form
		OP_ASL_3R  = 7'h0A, OP_ASR_3R  = 7'h0B, OP_ROL_3R  = 7'h0C,
		OP_ROR_3R  = 7'h0D, OP_LSR_3R  = 7'h0E,
		// 22-bit immediate forms
		OP_ADD_RI22  = 7'h11, OP_SUB_RI22  = 7'h12, OP_MUL_RI22  = 7'h13,
		OP_AND_RI22  = 7'h14, OP_OR_RI22   = 7'h15, OP_EOR_RI22  = 7'h16,
		OP_BIT_RI22  = 7'h17, OP_CMP_RI22  = 7'h18, OP_CMPU_RI22 = 7'h19,
		// 35-bit immediate forms
		OP_ADD_RI35  = 7'h21, OP_SUB_RI35  = 7'h22, OP_MUL_RI35  = 7'h23,
		OP_AND_RI35  = 7'h24, OP_OR_RI35   = 7'h25, OP_EOR_RI35  = 7'h26,
		OP_BIT_RI35  = 7'h27, OP_CMP_RI35  = 7'h28, OP_CMPU_RI35 = 7'h29,
		// immediate-shifted, special register moves, permute, csr
		OP_ADDIS   = 7'h30, OP_ANDIS   = 7'h31, OP_ORIS    = 7'h32,
		OP_MTX     = 7'h33, OP_MFX     = 7'h34, OP_PERM_3R = 7'h35,
		OP_CSR     = 7'h36,
		// loads, word then byte
		OP_LD_D8   = 7'h40, OP_LD_D22  = 7'h41, OP_LD_D35  = 7'h42,
		OP_LDB_D8  = 7'h44, OP_LDB_D22 = 7'h45, OP_LDB_D35 = 7'h46,
		// stores, word then byte
		OP_ST_D8   = 7'h48, OP_ST_D22  = 7'h49, OP_ST_D35  = 7'h4A,
		OP_STB_D8  = 7'h4C, OP_STB_D22 = 7'h4D, OP_STB_D35 = 7'h4E,
		// flow control
		OP_JAL     = 7'h50, OP_JAL_RN  = 7'h51,
		OP_BRANCH0 = 7'h52, OP_BRANCH1 = 7'h53,
		OP_BRKGRP  = 7'h54, OP_RETGRP  = 7'h55, OP_STPGRP  = 7'h56
	} opcode_t;

	// memory access size
	typedef enum logic [2:0]
	{
		BYTE = 3'd0,
		WORD = 3'd1
	} memSize_t;

	// ==================================================
	// instruction word views
	// ==================================================
	// general view; rb sits in the low five bits of const8
	typedef struct packed
	{
		logic [25:0] upper;
		// indexed addressing when clear on the D8 memory forms
		logic        one;
		logic [7:0]  const8;
		logic [4:0]  ra;
		logic [4:0]  rt;
		opcode_t     opcode;
	} instrGen_t;

	// branch view, 12-bit displacement above the condition
	typedef struct packed
	{
		logic [22:0] upper;
		logic [11:0] disp;
		logic [9:0]  cond;
		opcode_t     opcode;
	} instrBr_t;

	// one 52-bit word, two decodings
	typedef union packed
	{
		instrGen_t gen;
		instrBr_t  br;
	} instr_t;

	// ==================================================
	// decode bus
	// ==================================================
	typedef struct packed
	{
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
	} regSel_t;

	typedef struct packed
	{
		logic        alu;
		logic        alu0;
		logic        cmp;
		logic        fc;
		logic        load;
		logic        store;
		logic        mem;
		logic        memNdx;
		logic        jal;
		logic        br;
		logic        brkGrp;
		logic        retGrp;
		logic        rfw;
		memSize_t    memSz;
		// sign-extended constant
		logic [51:0] konst;
		regSel_t     regs;
	} decodeBus_t;

endpackage

// ==== design/decodeCtrl.sv ====
`timescale 1ns/1ns

module decodeCtrl
(
	input  logic clk,
	input  logic reset,
	input  logic fetchValid,
	input  logic stall,
	input  logic flush,
	output logic latchEn,
	output logic outEn,
	output logic fetchStall,
	output logic outValid
);

	// stage 1 holds the latched instruction, stage 2 is the output register
	logic s1Valid;
	logic advance;

	// output register can take a new bus when empty or when issue consumes it
	assign advance = ~outValid | ~stall;
	// move stage 1 forward only when there is something in it
	assign outEn = advance & s1Valid;
	// latch is free when empty, or when its contents move on this edge
	assign latchEn = ~s1Valid | advance;
	// both stages full and issue stalled
	assign fetchStall = ~latchEn;

	// ==================================================
	// valid bits
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			s1Valid  <= 1'b0;
			outValid <= 1'b0;
		end
		else if (flush)
		begin
			// drop both stages, including anything fetched this edge
			s1Valid  <= 1'b0;
			outValid <= 1'b0;
		end
		else
		begin
			// fetchValid here is the transfer, latchEn already low on stall
			if (latchEn)
				s1Valid <= fetchValid;
			if (advance)
				outValid <= s1Valid;
		end
	end

	// a stalled output stays valid until flushed
	holdUnderStall: assert property (@(posedge clk) disable iff (reset)
		(outValid && stall && !flush) |=> outValid)
		else $error("decodeCtrl: outValid dropped while issue stalled");

endmodule

// ==== design/instrClassifier.sv ====
`timescale 1ns/1ns

module instrClassifier
(
	input  decodePkg::instr_t     latched,
	output decodePkg::decodeBus_t flags
);

	import decodePkg::*;

	opcode_t op;

	assign op = latched.gen.opcode;

	// ==================================================
	// opcode groups
	// ==================================================
	// arithmetic, logic, shifts, compares, IS forms, moves, permute, csr
	function automatic logic isAlu(input opcode_t opc);
		case (opc)
			OP_MTX, OP_MFX, OP_ADDIS, OP_ANDIS, OP_ORIS, OP_PERM_3R, OP_CSR,
			OP_ADD_3R, OP_ADD_RI22, OP_ADD_RI35, OP_SUB_3R, OP_SUB_RI22, OP_SUB_RI35,
			OP_MUL_3R, OP_MUL_RI22, OP_MUL_RI35, OP_AND_3R, OP_AND_RI22, OP_AND_RI35,
			OP_OR_3R, OP_OR_RI22, OP_OR_RI35, OP_EOR_3R, OP_EOR_RI22, OP_EOR_RI35,
			OP_ASL_3R, OP_ASR_3R, OP_ROL_3R, OP_ROR_3R, OP_LSR_3R,
			OP_BIT_3R, OP_BIT_RI22, OP_BIT_RI35, OP_CMP_3R, OP_CMP_RI22, OP_CMP_RI35,
			OP_CMPU_3R, OP_CMPU_RI22, OP_CMPU_RI35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic isCmp(input opcode_t opc);
		case (opc)
			OP_CMP_3R, OP_CMP_RI22, OP_CMP_RI35, OP_CMPU_3R, OP_CMPU_RI22, OP_CMPU_RI35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// jumps, branches and the three group ops all redirect the fetch
	function automatic logic isFlowCtrl(input opcode_t opc);
		case (opc)
			OP_JAL, OP_JAL_RN, OP_BRANCH0, OP_BRANCH1, OP_BRKGRP, OP_RETGRP, OP_STPGRP:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic isLoad(input opcode_t opc);
		case (opc)
			OP_LD_D8, OP_LD_D22, OP_LD_D35, OP_LDB_D8, OP_LDB_D22, OP_LDB_D35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic logic isStore(input opcode_t opc);
		case (opc)
			OP_ST_D8, OP_ST_D22, OP_ST_D35, OP_STB_D8, OP_STB_D22, OP_STB_D35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	// memory group decoded on its own, cross-checked against load and store below
	function automatic logic isMem(input opcode_t opc);
		case (opc)
			OP_LD_D8, OP_LD_D22, OP_LD_D35, OP_LDB_D8, OP_LDB_D22, OP_LDB_D35,
			OP_ST_D8, OP_ST_D22, OP_ST_D35, OP_STB_D8, OP_STB_D22, OP_STB_D35:
				return 1'b1;
			default:
				return 1'b0;
		endcase
	endfunction

	function automatic memSize_t memSize(input opcode_t opc);
		case (opc)
			OP_LDB_D8, OP_LDB_D22, OP_LDB_D35, OP_STB_D8, OP_STB_D22, OP_STB_D35:
				return BYTE;
			default:
				return WORD;
		endcase
	endfunction

	// ==================================================
	// flag assembly
	// ==================================================
	always_comb
	begin
		// konst and regs stay zero, filled in by the merge at the top
		flags        = '0;
		flags.alu    = isAlu(op);
		flags.alu0   = (op == OP_CSR);
		flags.cmp    = isCmp(op);
		flags.fc     = isFlowCtrl(op);
		flags.load   = isLoad(op);
		flags.store  = isStore(op);
		flags.mem    = isMem(op);
		// only the short displacement forms can be indexed
		flags.memNdx = (op == OP_LD_D8 || op == OP_LDB_D8 || op == OP_ST_D8
			|| op == OP_STB_D8) && !latched.gen.one;
		flags.jal    = (op == OP_JAL) || (op == OP_JAL_RN);
		flags.br     = (op == OP_BRANCH0) || (op == OP_BRANCH1);
		flags.brkGrp = (op == OP_BRKGRP);
		flags.retGrp = (op == OP_RETGRP);
		flags.memSz  = memSize(op);
		// raw write flag, rt-zero rule comes later
		flags.rfw    = !(op == OP_STPGRP || flags.br || flags.store);
	end

	always_comb
	begin
		loadStoreExclusive: assert final (!(flags.load && flags.store))
			else $error("instrClassifier: load and store both set");
		memIsLoadOrStore: assert final (flags.mem == (flags.load | flags.store))
			else $error("instrClassifier: mem disagrees with load/store");
	end

endmodule

// ==== design/constExtractor.sv ====
`timescale 1ns/1ns

module constExtractor
(
	input  decodePkg::instr_t latched,
	output logic [51:0]       konst
);

	import decodePkg::*;

	opcode_t op;
	logic    has8;
	logic    has22;
	logic    has35;
	logic    isBranch;

	assign op = latched.gen.opcode;

	// ==================================================
	// constant size groups
	// ==================================================
	// 3R ops and D8 memory carry the 8-bit slot
	assign has8 = op inside {OP_ADD_3R, OP_SUB_3R, OP_MUL_3R, OP_AND_3R, OP_OR_3R,
		OP_EOR_3R, OP_BIT_3R, OP_CMP_3R, OP_CMPU_3R, OP_ASL_3R, OP_ASR_3R,
		OP_ROL_3R, OP_ROR_3R, OP_LSR_3R, OP_LD_D8, OP_ST_D8, OP_LDB_D8, OP_STB_D8};

	assign has22 = op inside {OP_ADD_RI22, OP_SUB_RI22, OP_MUL_RI22, OP_AND_RI22,
		OP_OR_RI22, OP_EOR_RI22, OP_BIT_RI22, OP_CMP_RI22, OP_CMPU_RI22,
		OP_LD_D22, OP_ST_D22, OP_LDB_D22, OP_STB_D22};

	// only checked, the 35-bit field is also the fallback
	assign has35 = op inside {OP_ADD_RI35, OP_SUB_RI35, OP_MUL_RI35, OP_AND_RI35,
		OP_OR_RI35, OP_EOR_RI35, OP_BIT_RI35, OP_CMP_RI35, OP_CMPU_RI35,
		OP_LD_D35, OP_ST_D35, OP_LDB_D35, OP_STB_D35};

	assign isBranch = (op == OP_BRANCH0) || (op == OP_BRANCH1);

	// priority select, then sign extend
	always_comb
	begin
		if (isBranch)
			konst = {{40{latched.br.disp[11]}}, latched.br.disp};
		else if (has8)
			konst = {{44{latched.gen.const8[7]}}, latched.gen.const8};
		else if (has22)
			konst = {{30{latched[38]}}, latched[38:17]};
		else
			konst = {{17{latched[51]}}, latched[51:17]};
	end

	always_comb
	begin
		oneSizeGroup: assert final ($onehot0({has8, has22, has35}))
			else $error("constExtractor: opcode in more than one size group");
	end

endmodule

// ==== design/regFieldExtractor.sv ====
`timescale 1ns/1ns

module regFieldExtractor
(
	input  decodePkg::instr_t  latched,
	input  logic               rfwRaw,
	output decodePkg::regSel_t regs,
	output logic               rfw
);

	import decodePkg::*;

	logic rtIsZero;

	// ==================================================
	// register fields
	// ==================================================
	// target and first source come straight from the general view
	assign regs.rt = latched.gen.rt;
	assign regs.ra = latched.gen.ra;
	// second source shares bits with the low end of const8
	assign regs.rb = latched.gen.const8[4:0];

	// r0 is hardwired and writes to it are thrown away
	assign rtIsZero = (latched.gen.rt == 5'd0);

	// write enable only when the opcode writes and the target is real
	assign rfw = rfwRaw & ~rtIsZero;

endmodule

// ==== design/decodeStageRegs.sv ====
`timescale 1ns/1ns

module decodeStageRegs
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  latchEn,
	input  logic                  outEn,
	input  decodePkg::instr_t     instr,
	input  decodePkg::decodeBus_t nextBus,
	output decodePkg::instr_t     latched,
	output decodePkg::decodeBus_t decoded
);

	import decodePkg::*;

	// ==================================================
	// stage 1, instruction latch
	// ==================================================
	always_ff @(posedge clk)
	begin
		if (reset)
			latched <= '0;
		else if (latchEn)
			latched <= instr;
	end

	// ==================================================
	// stage 2, decode bus to issue
	// ==================================================
	// holds under stall since outEn drops with advance
	always_ff @(posedge clk)
	begin
		if (reset)
			decoded <= '0;
		else if (outEn)
			decoded <= nextBus;
	end

endmodule

// ==== design/decodeTop.sv ====
`timescale 1ns/1ns

module decodeTop
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  fetchValid,
	input  decodePkg::instr_t     instr,
	input  logic                  stall,
	input  logic                  flush,
	output logic                  fetchStall,
	output logic                  outValid,
	output decodePkg::decodeBus_t decoded
);

	import decodePkg::*;

	logic        latchEn;
	logic        outEn;
	instr_t      latched;
	decodeBus_t  flags;
	logic [51:0] konst;
	regSel_t     regs;
	logic        rfw;
	decodeBus_t  nextBus;

	// ==================================================
	// control
	// ==================================================
	decodeCtrl u_decodeCtrl
	(
		.clk        (clk),
		.reset      (reset),
		.fetchValid (fetchValid),
		.stall      (stall),
		.flush      (flush),
		.latchEn    (latchEn),
		.outEn      (outEn),
		.fetchStall (fetchStall),
		.outValid   (outValid)
	);

	// ==================================================
	// datapath
	// ==================================================
	decodeStageRegs u_decodeStageRegs
	(
		.clk     (clk),
		.reset   (reset),
		.latchEn (latchEn),
		.outEn   (outEn),
		.instr   (instr),
		.nextBus (nextBus),
		.latched (latched),
		.decoded (decoded)
	);

	instrClassifier u_instrClassifier
	(
		.latched (latched),
		.flags   (flags)
	);

	constExtractor u_constExtractor
	(
		.latched (latched),
		.konst   (konst)
	);

	// raw write flag from the classifier gets the r0 rule here
	regFieldExtractor u_regFieldExtractor
	(
		.latched (latched),
		.rfwRaw  (flags.rfw),
		.regs    (regs),
		.rfw     (rfw)
	);

	// merge class flags with constant and register fields
	always_comb
	begin
		nextBus       = flags;
		nextBus.konst = konst;
		nextBus.regs  = regs;
		nextBus.rfw   = rfw;
	end

endmodule

// ==== verification/decodeTb.sv ====
`timescale 1ns/1ns

module decodeTb;

	import decodePkg::*;

	parameter logic [31:0] seed = 32'h49b9_ddc5;

	// run length, and a cycle budget well above what it needs
	localparam int numInstr      = 3000;
	localparam int timeoutCycles = numInstr * 6 + 2000;

	logic       clk;
	logic       reset;
	logic       fetchValid;
	instr_t     instr;
	logic       stall;
	logic       flush;
	logic       fetchStall;
	logic       outValid;
	decodeBus_t decoded;

	// reference model state
	decodeBus_t expQ[$];
	decodeBus_t expFront;
	int         expCount = 0;
	int         consumed = 0;
	int         cycleCount = 0;
	logic       offerTaken;
	logic       acceptD1;
	int         stallLeft;
	int         flushWait;
	logic       consumeNow;

	decodeTop u_decodeTop
	(
		.clk        (clk),
		.reset      (reset),
		.fetchValid (fetchValid),
		.instr      (instr),
		.stall      (stall),
		.flush      (flush),
		.fetchStall (fetchStall),
		.outValid   (outValid),
		.decoded    (decoded)
	);

	always #5 clk = ~clk;

	// ==================================================
	// expected decode
	// ==================================================
	function automatic logic isDefined(input logic [6:0] code);
		opcode_t o;
		int      i;
		o = o.first();
		for (i = 0; i < o.num(); i++)
		begin
			if (o == code)
				return 1'b1;
			o = o.next();
		end
		return 1'b0;
	endfunction

	function automatic opcode_t pickDefined(input int k);
		opcode_t o;
		int      i;
		o = o.first();
		for (i = 0; i < k; i++)
			o = o.next();
		return o;
	endfunction

	// upper opcode bits give the group, low nibble the operation and form
	function automatic decodeBus_t expectedBus(input instr_t w);
		decodeBus_t e;
		logic [6:0] code;
		logic [2:0] hi;
		logic [3:0] lo;
		logic       stopGrp;
		int         constSel;
		e        = '0;
		code     = w[6:0];
		hi       = code[6:4];
		lo       = code[3:0];
		stopGrp  = 1'b0;
		// 35-bit field unless a group says otherwise
		constSel = 35;
		e.memSz  = WORD;
		if (isDefined(code))
		begin
			case (hi)
				3'd0, 3'd1, 3'd2:
				begin
					// 3R, RI22 and RI35 arithmetic and logic
					e.alu    = 1'b1;
					e.cmp    = (lo == 4'h8) || (lo == 4'h9);
					constSel = (hi == 3'd0) ? 8 : ((hi == 3'd1) ? 22 : 35);
				end
				3'd3:
				begin
					e.alu  = 1'b1;
					e.alu0 = (lo == 4'h6);
				end
				3'd4:
				begin
					// bit 3 picks store, bit 2 byte size, low bits the displacement form
					e.store  = lo[3];
					e.load   = !lo[3];
					e.mem    = 1'b1;
					e.memSz  = lo[2] ? BYTE : WORD;
					constSel = (lo[1:0] == 2'd0) ? 8 : ((lo[1:0] == 2'd1) ? 22 : 35);
					e.memNdx = (lo[1:0] == 2'd0) && !w.gen.one;
				end
				3'd5:
				begin
					e.fc     = 1'b1;
					e.jal    = (lo == 4'h0) || (lo == 4'h1);
					e.br     = (lo == 4'h2) || (lo == 4'h3);
					e.brkGrp = (lo == 4'h4);
					e.retGrp = (lo == 4'h5);
					stopGrp  = (lo == 4'h6);
					if (e.br)
						constSel = 12;
				end
				default:
				begin
					e.alu = 1'b0;
				end
			endcase
		end
		case (constSel)
			12:      e.konst = 52'($signed(w[28:17]));
			8:       e.konst = 52'($signed(w[24:17]));
			22:      e.konst = 52'($signed(w[38:17]));
			default: e.konst = 52'($signed(w[51:17]));
		endcase
		e.regs.rt = w[11:7];
		e.regs.ra = w[16:12];
		e.regs.rb = w[21:17];
		// no write for stores, branches, stop group or r0
		e.rfw = !(e.store || e.br || stopGrp) && (w[11:7] != 5'd0);
		return e;
	endfunction

	function automatic logic [14:0] flagField(input decodeBus_t b);
		return {b.alu, b.alu0, b.cmp, b.fc, b.load, b.store, b.mem, b.memNdx,
			b.jal, b.br, b.brkGrp, b.retGrp, b.memSz};
	endfunction

	// ==================================================
	// stimulus
	// ==================================================
	function automatic instr_t randomInstr();
		logic [63:0] bits;
		logic [6:0]  code;
		opcode_t     probe;
		instr_t      w;
		bits = {$urandom(), $urandom()};
		// about one in ten is an undefined code
		if ($urandom % 10 == 0)
		begin
			code = 7'($urandom);
			while (isDefined(code))
				code = 7'($urandom);
		end
		else
			code = pickDefined(int'($urandom % probe.num()));
		// rt zero now and then for the r0 write rule
		if ($urandom % 8 == 0)
			bits[4:0] = 5'd0;
		w = {bits[44:0], code};
		return w;
	endfunction

	task automatic driveInputs();
		// stall comes in short bursts
		if (stallLeft > 0)
		begin
			stall     = 1'b1;
			stallLeft = stallLeft - 1;
		end
		else if ($urandom % 100 < 10)
		begin
			stall     = 1'b1;
			stallLeft = int'($urandom % 6);
		end
		else
			stall = 1'b0;
		// one-cycle flush pulse every 120 to 180 cycles
		if (flushWait == 0)
		begin
			flush     = 1'b1;
			flushWait = 120 + int'($urandom % 61);
		end
		else
		begin
			flush     = 1'b0;
			flushWait = flushWait - 1;
		end
		// an offer not yet taken is held as it is
		if (!(fetchValid && !offerTaken))
		begin
			fetchValid = ($urandom % 100) < 80;
			instr      = randomInstr();
		end
	endtask

	// ==================================================
	// reference queue
	// ==================================================
	always @(posedge clk)
	begin
		cycleCount <= cycleCount + 1;
		if (reset)
		begin
			expQ.delete();
			offerTaken <= 1'b1;
			acceptD1   <= 1'b0;
		end
		else
		begin
			if (outValid && !stall && expQ.size() != 0)
			begin
				void'(expQ.pop_front());
				consumed <= consumed + 1;
			end
			// an instruction taken on a flush edge is dropped too
			if (flush)
				expQ.delete();
			else if (fetchValid && !fetchStall)
				expQ.push_back(expectedBus(instr));
			offerTaken <= !fetchValid || !fetchStall;
			acceptD1   <= fetchValid && !fetchStall && !flush;
		end
		expCount <= expQ.size();
		if (expQ.size() != 0)
			expFront <= expQ[0];
		else
			expFront <= '0;
	end

	assign consumeNow = outValid && !stall;

	// ==================================================
	// checks
	// ==================================================
	task automatic valueMismatch(input string testName, input logic [63:0] expected,
		input logic [63:0] actual);
		$display("CHECK FAILED %s expected %h actual %h", testName, expected, actual);
		$display("TEST FAIL");
		$fatal(1, "decoded output differs from the expected value");
	endtask

	task automatic protocolError(input string what);
		$display("ERROR: %s", what);
		$display("TEST FAIL");
		$fatal(1, "handshake behavior is wrong");
	endtask

	noSpurious: assert property (@(posedge clk) disable iff (reset)
		consumeNow |-> (expCount != 0))
		else protocolError("issue saw a valid output with no instruction outstanding");

	classFlags: assert property (@(posedge clk) disable iff (reset)
		(consumeNow && expCount != 0) |-> (flagField(decoded) == flagField(expFront)))
		else valueMismatch("classFlags", 64'(flagField($sampled(expFront))),
			64'(flagField($sampled(decoded))));

	constValue: assert property (@(posedge clk) disable iff (reset)
		(consumeNow && expCount != 0) |-> (decoded.konst == expFront.konst))
		else valueMismatch("constant", 64'($sampled(expFront.konst)),
			64'($sampled(decoded.konst)));

	regFields: assert property (@(posedge clk) disable iff (reset)
		(consumeNow && expCount != 0)
		|-> ({decoded.regs, decoded.rfw} == {expFront.regs, expFront.rfw}))
		else valueMismatch("registers", 64'({$sampled(expFront.regs), $sampled(expFront.rfw)}),
			64'({$sampled(decoded.regs), $sampled(decoded.rfw)}));

	// taken at N with no stall or flush at N+1 means valid after N+1
	twoCycleLatency: assert property (@(posedge clk) disable iff (reset)
		(acceptD1 && !stall && !flush) |=> outValid)
		else protocolError("accepted instruction did not reach the output two cycles later");

	stallHold: assert property (@(posedge clk) disable iff (reset)
		(outValid && stall && !flush) |=> (outValid && $stable(decoded)))
		else protocolError("decoded output changed while issue was stalled");

	// fetch is held off only when both stages are full under stall
	fetchStallRule: assert property (@(posedge clk) disable iff (reset)
		fetchStall == (expCount == 2 && stall))
		else protocolError("fetchStall does not match the stage occupancy");

	occupancy: assert property (@(posedge clk) disable iff (reset)
		expCount <= 2)
		else protocolError("more than two instructions accepted into the stage");

	flushEmpties: assert property (@(posedge clk) disable iff (reset)
		flush |=> !outValid)
		else protocolError("output still valid in the cycle after a flush");

	resetIdle: assert property (@(posedge clk)
		reset |=> (!outValid && !fetchStall && decoded == '0))
		else protocolError("stage not idle and cleared after reset");

	// ==================================================
	// run control
	// ==================================================
	initial
	begin
		void'($urandom(seed));
		clk        = 1'b0;
		reset      = 1'b1;
		fetchValid = 1'b0;
		instr      = '0;
		stall      = 1'b0;
		flush      = 1'b0;
		stallLeft  = 0;
		flushWait  = 120 + int'($urandom % 61);
		repeat (4) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		while (consumed < numInstr && cycleCount < timeoutCycles)
		begin
			driveInputs();
			@(negedge clk);
		end
		if (consumed >= numInstr)
		begin
			$display("TEST PASS");
			$finish;
		end
		else
		begin
			$display("TEST FAIL");
			$fatal(1, "timeout after %0d cycles with %0d of %0d instructions consumed",
				cycleCount, consumed, numInstr);
		end
	end

endmodule

// ==== sim.f ====
design/decodePkg.sv
design/decodeCtrl.sv
design/instrClassifier.sv
design/constExtractor.sv
design/regFieldExtractor.sv
design/decodeStageRegs.sv
design/decodeTop.sv
verification/decodeTb.sv

// ==== Makefile ====
# Verilator build for the decode stage testbench

TOP       ?= decodeTb
SEED      ?= 1236917701
VERILATOR ?= verilator
VFLAGS    ?= --timing --assert
BUILD     ?= obj_dir
FILELIST  ?= sim.f

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -Gseed=$(SEED) \
		-Mdir $(BUILD) -f $(FILELIST)
	./$(BUILD)/V$(TOP)

clean:
	rm -rf $(BUILD)
